// ==== design/engine_packet_pkg.sv ====
// Engine packet fields
// Widths of the data word, destination and sequence identifier that
// every packet stream in the engine carries.

package engine_packet_pkg;

    // ------------------------------
    // Packet payload fields
    // ------------------------------

    // Data word under test
    typedef logic [31:0] data_t;

    // Destination of a packet
    typedef logic [7:0] route_t;

    // Sequence the packet belongs to
    typedef logic [7:0] seq_id_t;

endpackage : engine_packet_pkg

// ==== design/filter_cond_pkg.sv ====
// Filter and conditional-route definitions
// Compare operations, run states of the generator, the width of the
// output packet counter and the depth of the evaluation pipeline.

package filter_cond_pkg;

    // ------------------------------
    // Compare and run control
    // ------------------------------

    // Unsigned compare of data against the operand
    typedef enum logic [1:0] {
        EQ,
        NE,
        LT,
        GT
    } filter_op_e;

    // Idle waits for a configuration, drain waits for the last packet to leave
    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_RUN,
        GEN_DRAIN
    } gen_state_e;

    // Packets that left the output since the last configuration
    typedef logic [15:0] count_t;

    // Register, compare, route
    localparam int PIPE_STAGES = 3;

endpackage : filter_cond_pkg

// ==== design/packet_stream_if.sv ====
`timescale 1ns/1ps

// Packet stream
// One packet word with its valid/ready flow control and the
// programmable-full flag that the buffer returns to its producer.

interface packet_stream_if
    import engine_packet_pkg::*;
();

    logic    valid;
    logic    ready;
    logic    prog_full;
    data_t   data;
    route_t  dest;
    seq_id_t seq_id;
    logic    last;

    // Producer side
    modport source (
        output valid, data, dest, seq_id, last,
        input  ready, prog_full
    );

    // Consumer side that also owns the back-pressure flag
    modport sink (
        input  valid, data, dest, seq_id, last,
        output ready, prog_full
    );

endinterface : packet_stream_if

// ==== design/filter_cond_evaluator.sv ====
`timescale 1ns/1ps

// Filter and conditional-route evaluator
// Runs the idle/run/drain state machine, holds the active configuration
// and passes accepted packets through a three-stage pipeline: input
// register, compare, then filter and route. Stage 3 writes the FIFO.

module filter_cond_evaluator
    import engine_packet_pkg::*;
    import filter_cond_pkg::*;
(
    input  logic            ap_clk,
    input  logic            areset_generator,
    input  logic            cfg_valid,
    output logic            cfg_ready,
    input  filter_op_e      cfg_op,
    input  data_t           cfg_operand,
    input  logic            cfg_invert,
    input  logic            cfg_conditional,
    input  route_t          cfg_route_if,
    input  route_t          cfg_route_else,
    input  logic            in_valid,
    output logic            in_ready,
    input  data_t           in_data,
    input  route_t          in_dest,
    input  seq_id_t         in_seq_id,
    input  logic            in_last,
    input  logic            last_sent,
    output logic            done,
    packet_stream_if.source stream
);

gen_state_e state;
gen_state_e next_state;

// Active configuration
filter_op_e op_reg;
data_t      operand_reg;
logic       invert_reg;
logic       conditional_reg;
route_t     route_if_reg;
route_t     route_else_reg;

logic in_accept;

// Pipeline stages
logic    s1_valid;
data_t   s1_data;
route_t  s1_dest;
seq_id_t s1_seq_id;
logic    s1_last;

logic    s2_valid;
logic    s2_hit;
data_t   s2_data;
route_t  s2_dest;
seq_id_t s2_seq_id;
logic    s2_last;
logic    s2_pass;
logic    s2_keep;
route_t  s2_route;

logic    s3_valid;
data_t   s3_data;
route_t  s3_dest;
seq_id_t s3_seq_id;
logic    s3_last;

// ------------------------------
// Run state machine
// ------------------------------
assign cfg_ready = (state == GEN_IDLE);
assign done      = (state == GEN_IDLE);
// Input stops while the FIFO cannot absorb a full pipeline
assign in_ready  = (state == GEN_RUN) & ~stream.prog_full & stream.ready;
assign in_accept = in_valid & in_ready;

always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        state <= GEN_IDLE;
    end else begin
        state <= next_state;
    end
end

always_comb begin
    next_state = state;
    case (state)
        GEN_IDLE: begin
            if (cfg_valid)
                next_state = GEN_RUN;
        end
        GEN_RUN: begin
            if (in_accept & in_last)
                next_state = GEN_DRAIN;
        end
        GEN_DRAIN: begin
            if (last_sent)
                next_state = GEN_IDLE;
        end
        default: begin
            next_state = GEN_IDLE;
        end
    endcase
end

always_ff @(posedge ap_clk) begin
    if (cfg_valid & cfg_ready) begin
        op_reg          <= cfg_op;
        operand_reg     <= cfg_operand;
        invert_reg      <= cfg_invert;
        conditional_reg <= cfg_conditional;
        route_if_reg    <= cfg_route_if;
        route_else_reg  <= cfg_route_else;
    end
end

// ------------------------------
// Compare and route pipeline
// ------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        s1_valid <= 1'b0;
        s2_valid <= 1'b0;
        s3_valid <= 1'b0;
    end else begin
        s1_valid <= in_accept;
        s2_valid <= s1_valid;
        s3_valid <= s2_valid & s2_keep;
    end
end

// Stage 1 registers the accepted word
always_ff @(posedge ap_clk) begin
    s1_data   <= in_data;
    s1_dest   <= in_dest;
    s1_seq_id <= in_seq_id;
    s1_last   <= in_last;
end

// Stage 2 compares, unsigned
always_ff @(posedge ap_clk) begin
    s2_data   <= s1_data;
    s2_dest   <= s1_dest;
    s2_seq_id <= s1_seq_id;
    s2_last   <= s1_last;
    case (op_reg)
        EQ:      s2_hit <= (s1_data == operand_reg);
        NE:      s2_hit <= (s1_data != operand_reg);
        LT:      s2_hit <= (s1_data < operand_reg);
        GT:      s2_hit <= (s1_data > operand_reg);
        default: s2_hit <= 1'b0;
    endcase
end

// Conditional mode forwards all, filter mode only passing words
// A last word always goes out so the run can finish
assign s2_pass  = s2_hit ^ invert_reg;
assign s2_keep  = conditional_reg | s2_last | s2_pass;
assign s2_route = conditional_reg ? (s2_pass ? route_if_reg : route_else_reg) : s2_dest;

always_ff @(posedge ap_clk) begin
    s3_data   <= s2_data;
    s3_dest   <= s2_route;
    s3_seq_id <= s2_seq_id;
    s3_last   <= s2_last;
end

assign stream.valid  = s3_valid;
assign stream.data   = s3_data;
assign stream.dest   = s3_dest;
assign stream.seq_id = s3_seq_id;
assign stream.last   = s3_last;

endmodule : filter_cond_evaluator

// ==== design/packet_fifo.sv ====
`timescale 1ns/1ps

// Packet FIFO
// Circular buffer with first-word-fall-through output. Programmable
// full rises early enough that the evaluator pipeline can always empty
// into it, so the write side never needs to stall.

module packet_fifo
    import engine_packet_pkg::*;
    import filter_cond_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic            ap_clk,
    input  logic            areset_generator,
    packet_stream_if.sink   wr,
    packet_stream_if.source rd
);

localparam int ADDR_W      = $clog2(FIFO_DEPTH);
localparam int CNT_W       = ADDR_W + 1;
localparam int WORD_W      = $bits(data_t) + $bits(route_t) + $bits(seq_id_t) + 1;
localparam int PROG_THRESH = FIFO_DEPTH - PIPE_STAGES - 1;

logic [WORD_W-1:0] mem [FIFO_DEPTH];
logic [WORD_W-1:0] rd_word;
logic [ADDR_W-1:0] wr_ptr;
logic [ADDR_W-1:0] rd_ptr;
logic [CNT_W-1:0]  count;
logic              empty;
logic              full;
logic              push;
logic              pop;

// ------------------------------
// Flags
// ------------------------------
assign empty = (count == '0);
assign full  = (count == CNT_W'(FIFO_DEPTH));
assign push  = wr.valid & ~full;
assign pop   = rd.valid & rd.ready;

assign wr.ready     = 1'b1;
assign wr.prog_full = (count >= CNT_W'(PROG_THRESH));

// ------------------------------
// Storage and pointers
// ------------------------------
always_ff @(posedge ap_clk) begin
    if (push)
        mem[wr_ptr] <= {wr.data, wr.dest, wr.seq_id, wr.last};
end

always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push)
            wr_ptr <= wr_ptr + ADDR_W'(1);
        if (pop)
            rd_ptr <= rd_ptr + ADDR_W'(1);
        case ({push, pop})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;
        endcase
    end
end

// Head word is visible without a read request
assign rd_word  = mem[rd_ptr];
assign rd.valid = ~empty;
assign {rd.data, rd.dest, rd.seq_id, rd.last} = rd_word;

endmodule : packet_fifo

// ==== design/request_emitter.sv ====
`timescale 1ns/1ps

// Request emitter
// Single output register between the FIFO and the engine output port.
// Counts output handshakes and pulses last_sent once the word that
// closes the run has been taken.

module request_emitter
    import engine_packet_pkg::*;
    import filter_cond_pkg::*;
(
    input  logic          ap_clk,
    input  logic          areset_generator,
    packet_stream_if.sink stream,
    input  logic          cfg_load,
    output logic          out_valid,
    input  logic          out_ready,
    output data_t         out_data,
    output route_t        out_dest,
    output seq_id_t       out_seq_id,
    output logic          out_last,
    output count_t        pkt_count,
    output logic          last_sent
);

logic out_fire;
logic take;

assign out_fire = out_valid & out_ready;

// Refill when empty or when the held word leaves this cycle
assign stream.ready     = ~out_valid | out_ready;
assign stream.prog_full = 1'b0;
assign take             = stream.valid & stream.ready;

// ------------------------------
// Output register
// ------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        out_valid <= 1'b0;
    end else if (take) begin
        out_valid <= 1'b1;
    end else if (out_ready) begin
        out_valid <= 1'b0;
    end
end

always_ff @(posedge ap_clk) begin
    if (take) begin
        out_data   <= stream.data;
        out_dest   <= stream.dest;
        out_seq_id <= stream.seq_id;
        out_last   <= stream.last;
    end
end

// Counter and end-of-run pulse
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        pkt_count <= '0;
        last_sent <= 1'b0;
    end else begin
        last_sent <= out_fire & out_last;
        if (cfg_load)
            pkt_count <= '0;
        else if (out_fire)
            pkt_count <= pkt_count + count_t'(1);
    end
end

endmodule : request_emitter

// ==== design/engine_filter_cond.sv ====
`timescale 1ns/1ps

// Filter and conditional-route engine
// Evaluator feeds a packet FIFO, the emitter drains it to the output
// port. Configuration, input and output streams are plain ports.

module engine_filter_cond
    import engine_packet_pkg::*;
    import filter_cond_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       ap_clk,
    input  logic       areset_generator,
    // Configuration
    input  logic       cfg_valid,
    output logic       cfg_ready,
    input  filter_op_e cfg_op,
    input  data_t      cfg_operand,
    input  logic       cfg_invert,
    input  logic       cfg_conditional,
    input  route_t     cfg_route_if,
    input  route_t     cfg_route_else,
    // Input stream
    input  logic       in_valid,
    output logic       in_ready,
    input  data_t      in_data,
    input  route_t     in_dest,
    input  seq_id_t    in_seq_id,
    input  logic       in_last,
    // Output stream
    output logic       out_valid,
    input  logic       out_ready,
    output data_t      out_data,
    output route_t     out_dest,
    output seq_id_t    out_seq_id,
    output logic       out_last,
    // Status
    output count_t     pkt_count,
    output logic       done
);

logic cfg_load;
logic last_sent;

packet_stream_if eval_to_fifo ();
packet_stream_if fifo_to_emit ();

// Configuration handshake restarts the output count
assign cfg_load = cfg_valid & cfg_ready;

// ------------------------------
// Producer, buffer, consumer
// ------------------------------
filter_cond_evaluator u_evaluator (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator),
    .cfg_valid       (cfg_valid),
    .cfg_ready       (cfg_ready),
    .cfg_op          (cfg_op),
    .cfg_operand     (cfg_operand),
    .cfg_invert      (cfg_invert),
    .cfg_conditional (cfg_conditional),
    .cfg_route_if    (cfg_route_if),
    .cfg_route_else  (cfg_route_else),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .in_data         (in_data),
    .in_dest         (in_dest),
    .in_seq_id       (in_seq_id),
    .in_last         (in_last),
    .last_sent       (last_sent),
    .done            (done),
    .stream          (eval_to_fifo)
);

packet_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
) u_fifo (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator),
    .wr              (eval_to_fifo),
    .rd              (fifo_to_emit)
);

request_emitter u_emitter (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator),
    .stream          (fifo_to_emit),
    .cfg_load        (cfg_load),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_data        (out_data),
    .out_dest        (out_dest),
    .out_seq_id      (out_seq_id),
    .out_last        (out_last),
    .pkt_count       (pkt_count),
    .last_sent       (last_sent)
);

endmodule : engine_filter_cond

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

// Testbench clock and reset
// Free-running clock and a synchronous reset held for a fixed number
// of rising edges after time zero.

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic ap_clk,
    output logic areset_generator
);

initial begin
    ap_clk = 1'b0;
    forever #(PERIOD_NS / 2) ap_clk = ~ap_clk;
end

// Release 1 ns after an edge
initial begin
    areset_generator = 1'b1;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    #1;
    areset_generator = 1'b0;
end

endmodule : tb_clock_gen

// ==== tb/engine_filter_cond_properties.sv ====
`timescale 1ns/1ps

// Engine handshake properties
// Output word must hold while the sink stalls, and the configuration
// and input ports are never ready in the same cycle.

module engine_filter_cond_properties
    import engine_packet_pkg::*;
(
    input logic    ap_clk,
    input logic    areset_generator,
    input logic    cfg_ready,
    input logic    in_ready,
    input logic    out_valid,
    input logic    out_ready,
    input data_t   out_data,
    input route_t  out_dest,
    input seq_id_t out_seq_id,
    input logic    out_last
);

// ------------------------------
// Output stream stability
// ------------------------------
a_out_valid_hold: assert property (
    @(posedge ap_clk) disable iff (areset_generator)
    (out_valid && !out_ready) |=> out_valid
) else $error("out_valid dropped while out_ready was low");

a_out_payload_hold: assert property (
    @(posedge ap_clk) disable iff (areset_generator)
    (out_valid && !out_ready) |=> ($stable(out_data) && $stable(out_dest) &&
                                   $stable(out_seq_id) && $stable(out_last))
) else $error("output payload changed while out_ready was low");

// Config is taken only in idle, packets only while running
a_ready_exclusive: assert property (
    @(posedge ap_clk) disable iff (areset_generator)
    !(in_ready && cfg_ready)
) else $error("in_ready and cfg_ready were high together");

endmodule : engine_filter_cond_properties

bind engine_filter_cond engine_filter_cond_properties u_properties (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator),
    .cfg_ready       (cfg_ready),
    .in_ready        (in_ready),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_data        (out_data),
    .out_dest        (out_dest),
    .out_seq_id      (out_seq_id),
    .out_last        (out_last)
);

// ==== tb/tb_engine_filter_cond.sv ====
`timescale 1ns/1ps

// Filter and conditional-route engine testbench
// Loads a configuration per run, sends packets, predicts the output
// with a reference model and compares every output handshake.

module tb_engine_filter_cond
    import engine_packet_pkg::*;
    import filter_cond_pkg::*;
();

typedef struct packed {
    data_t   data;
    route_t  dest;
    seq_id_t seq_id;
    logic    last;
} exp_pkt_t;

localparam int PKTS_PER_RUN   = 12;
localparam int LAST_RUN_PKTS  = 6;
localparam int STALL_RUN_PKTS = 40;
localparam int TOTAL_PKTS     = 10 * PKTS_PER_RUN + LAST_RUN_PKTS + STALL_RUN_PKTS;
localparam int TIMEOUT_CYCLES = 40 * TOTAL_PKTS + 200;

logic       ap_clk;
logic       areset_generator;
logic       cfg_valid;
logic       cfg_ready;
filter_op_e cfg_op;
data_t      cfg_operand;
logic       cfg_invert;
logic       cfg_conditional;
route_t     cfg_route_if;
route_t     cfg_route_else;
logic       in_valid;
logic       in_ready;
data_t      in_data;
route_t     in_dest;
seq_id_t    in_seq_id;
logic       in_last;
logic       out_valid;
logic       out_ready;
data_t      out_data;
route_t     out_dest;
seq_id_t    out_seq_id;
logic       out_last;
count_t     pkt_count;
logic       done;

exp_pkt_t    exp_q[$];
logic [31:0] rng_data;
logic [31:0] rng_ready;
bit          stall_mode;
int          out_seen;
int          fwd_count;
int          error_count;
int          cycles;
seq_id_t     next_seq;

tb_clock_gen #(
    .PERIOD_NS   (10),
    .RESET_CYCLES(8)
) u_clock_gen (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator)
);

engine_filter_cond #(
    .FIFO_DEPTH(16)
) u_engine_filter_cond (
    .ap_clk(ap_clk), .areset_generator(areset_generator),
    .cfg_valid(cfg_valid), .cfg_ready(cfg_ready), .cfg_op(cfg_op),
    .cfg_operand(cfg_operand), .cfg_invert(cfg_invert),
    .cfg_conditional(cfg_conditional), .cfg_route_if(cfg_route_if),
    .cfg_route_else(cfg_route_else),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
    .in_dest(in_dest), .in_seq_id(in_seq_id), .in_last(in_last),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
    .out_dest(out_dest), .out_seq_id(out_seq_id), .out_last(out_last),
    .pkt_count(pkt_count), .done(done)
);

// ------------------------------
// Random numbers and reference
// ------------------------------
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// Keep decision and destination for one packet under the loaded config
function automatic bit filter_ref(input data_t data, input route_t dest,
                                  input logic last, output route_t route);
    bit hit;
    bit pass;
    case (cfg_op)
        EQ:      hit = (data == cfg_operand);
        NE:      hit = (data != cfg_operand);
        LT:      hit = (data < cfg_operand);
        default: hit = (data > cfg_operand);
    endcase
    pass = (hit != cfg_invert);
    if (cfg_conditional) begin
        route = pass ? cfg_route_if : cfg_route_else;
        return 1'b1;
    end
    route = dest;
    return pass || last;
endfunction

// ------------------------------
// Failure reporting and checks
// ------------------------------
task automatic fail_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first failure");
endtask

task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
        fail_run($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
endtask

task automatic check_route(input string name, input route_t got, input route_t exp);
    if (got !== exp)
        fail_run($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
endtask

task automatic check_seq(input string name, input seq_id_t got, input seq_id_t exp);
    if (got !== exp)
        fail_run($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
endtask

task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp)
        fail_run($sformatf("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
        fail_run($sformatf("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp));
endtask

// ------------------------------
// Stimulus tasks
// ------------------------------
task automatic load_config(input filter_op_e op, input data_t operand, input logic invert,
                           input logic conditional, input route_t rif, input route_t relse);
    bit taken;
    cfg_valid       = 1'b1;
    cfg_op          = op;
    cfg_operand     = operand;
    cfg_invert      = invert;
    cfg_conditional = conditional;
    cfg_route_if    = rif;
    cfg_route_else  = relse;
    do begin
        @(negedge ap_clk);
        taken = cfg_ready;
        @(posedge ap_clk);
        #1;
    end while (!taken);
    cfg_valid = 1'b0;
    out_seen  = 0;
    fwd_count = 0;
endtask

// Holds the word until in_ready, then records the prediction
task automatic send_packet(input data_t data, input route_t dest, input logic last);
    bit       taken;
    route_t   route;
    exp_pkt_t pkt;
    in_valid  = 1'b1;
    in_data   = data;
    in_dest   = dest;
    in_seq_id = next_seq;
    in_last   = last;
    do begin
        @(negedge ap_clk);
        taken = in_ready;
        if (taken && filter_ref(data, dest, last, route)) begin
            pkt = '{data: data, dest: route, seq_id: next_seq, last: last};
            exp_q.push_back(pkt);
            fwd_count++;
        end
        @(posedge ap_clk);
        #1;
    end while (!taken);
    in_valid = 1'b0;
    next_seq = next_seq + seq_id_t'(1);
endtask

// Mostly small values near the operands and some full-width words
task automatic run_packets(input int n, input bit fail_last);
    data_t data;
    for (int i = 0; i < n; i++) begin
        rng_data = lcg_next(rng_data);
        data     = (rng_data[31:30] != 2'b00) ? data_t'(rng_data[27:26]) : rng_data;
        if (fail_last && i == n - 1)
            data = cfg_operand + data_t'(1);
        send_packet(data, route_t'(rng_data[15:8]), i == n - 1);
        if (rng_data[20]) begin
            @(posedge ap_clk);
            #1;
        end
    end
endtask

task automatic wait_done();
    do
        @(negedge ap_clk);
    while (!done);
    if (exp_q.size() != 0)
        fail_run($sformatf("Run ended with %0d expected packets never output", exp_q.size()));
    check_count("pkt_count", pkt_count, count_t'(fwd_count));
    @(posedge ap_clk);
    #1;
endtask

// ------------------------------
// Output ready pattern
// ------------------------------
// Under stalls the sink is ready about one cycle in eight, so the FIFO fills
initial begin
    forever begin
        @(posedge ap_clk);
        #1;
        rng_ready = lcg_next(rng_ready);
        out_ready = stall_mode ? (rng_ready[31:29] == 3'b000) : 1'b1;
    end
end

// Compare each output handshake against the queue
initial begin
    exp_pkt_t exp;
    forever begin
        @(negedge ap_clk);
        if (!areset_generator && out_valid && out_ready) begin
            if (exp_q.size() == 0)
                fail_run("Output packet appeared with no packet expected");
            exp = exp_q.pop_front();
            check_data("out_data", out_data, exp.data);
            check_route("out_dest", out_dest, exp.dest);
            check_seq("out_seq_id", out_seq_id, exp.seq_id);
            check_flag("out_last", out_last, exp.last);
            check_count("pkt_count", pkt_count, count_t'(out_seen));
            out_seen++;
        end
    end
end

initial begin
    cycles = 0;
    forever begin
        @(posedge ap_clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            fail_run($sformatf("Timeout: run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
    end
end

// ------------------------------
// Test sequence
// ------------------------------
initial begin
    cfg_valid       = 1'b0;
    cfg_op          = EQ;
    cfg_operand     = '0;
    cfg_invert      = 1'b0;
    cfg_conditional = 1'b0;
    cfg_route_if    = '0;
    cfg_route_else  = '0;
    in_valid        = 1'b0;
    in_data         = '0;
    in_dest         = '0;
    in_seq_id       = '0;
    in_last         = 1'b0;
    out_ready       = 1'b1;
    rng_data        = 32'd27;
    rng_ready       = 32'd27;
    stall_mode      = 1'b0;
    out_seen        = 0;
    fwd_count       = 0;
    error_count     = 0;
    next_seq        = '0;

    @(negedge ap_clk);
    while (areset_generator)
        @(negedge ap_clk);
    check_flag("done", done, 1'b1);
    check_flag("cfg_ready", cfg_ready, 1'b1);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("in_ready", in_ready, 1'b0);
    check_count("pkt_count", pkt_count, count_t'(0));
    @(posedge ap_clk);
    #1;

    // Filter mode, every compare with both invert settings
    for (int op = 0; op < 4; op++) begin
        for (int inv = 0; inv < 2; inv++) begin
            load_config(filter_op_e'(op[1:0]), data_t'(2), inv[0], 1'b0, 8'hA0, 8'hB0);
            run_packets(PKTS_PER_RUN, 1'b0);
            wait_done();
        end
    end

    // Conditional mode under output stalls
    stall_mode = 1'b1;
    for (int inv = 0; inv < 2; inv++) begin
        load_config(LT, data_t'(2), inv[0], 1'b1, 8'h11, 8'h22);
        run_packets(PKTS_PER_RUN, 1'b0);
        wait_done();
    end

    // Last packet fails the filter and still closes the run
    stall_mode = 1'b0;
    load_config(EQ, data_t'(5), 1'b0, 1'b0, 8'h33, 8'h44);
    run_packets(LAST_RUN_PKTS, 1'b1);
    wait_done();

    // Long run with random back-pressure through the FIFO
    stall_mode = 1'b1;
    load_config(GT, data_t'(1), 1'b0, 1'b0, 8'h55, 8'h66);
    run_packets(STALL_RUN_PKTS, 1'b0);
    wait_done();

    if (error_count == 0) begin
        $display("NO ERRORS");
        $finish;
    end else begin
        fail_run("Checks failed during the run");
    end
end

endmodule : tb_engine_filter_cond

// ==== list.f ====
design/engine_packet_pkg.sv
design/filter_cond_pkg.sv
design/packet_stream_if.sv
design/filter_cond_evaluator.sv
design/packet_fifo.sv
design/request_emitter.sv
design/engine_filter_cond.sv
tb/tb_clock_gen.sv
tb/engine_filter_cond_properties.sv
tb/tb_engine_filter_cond.sv

// ==== Bender.yml ====
package:
  name: engine_filter_cond

sources:
  - design/engine_packet_pkg.sv
  - design/filter_cond_pkg.sv
  - design/packet_stream_if.sv
  - design/filter_cond_evaluator.sv
  - design/packet_fifo.sv
  - design/request_emitter.sv
  - design/engine_filter_cond.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/engine_filter_cond_properties.sv
      - tb/tb_engine_filter_cond.sv
